//--- Makefile
# Verilator lint, simulation and cleanup for the pipeline control block
VERILATOR   ?= verilator
TOP         ?= pipe_ctrl_tb
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
LINT_FLAGS  ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --assert
SIM_ARGS    ?= +verilator+error+limit+1000
PASS_TEXT   ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+rtl
rtl/pipe_pkg.sv
rtl/hazard_if.sv
rtl/hazard_unit.sv
rtl/pc_unit.sv
rtl/stage_regs.sv
rtl/pipe_ctrl_top.sv
dv/pipe_ctrl_chk.sv
dv/pipe_ctrl_tb.sv

//--- dv/pipe_ctrl_chk.sv
// concurrent checks on the pipeline control ports, bound onto pipe_ctrl_top
// a small reference of the four stages is built from the issued instruction stream
// only the opcodes of pipe_pkg are modelled, instr must carry one of them
`timescale 1ns/100ps
`include "pipe_config.svh"

module pipe_ctrl_chk (
	input logic                    CLK,
	input logic                    reset,
	input logic                    ihit,
	input logic [`PIPE_DATA_W-1:0] instr,
	input logic [`PIPE_DATA_W-1:0] pc,
	input logic [`PIPE_REG_W-1:0]  rs_addr,
	input logic [`PIPE_REG_W-1:0]  rt_addr,
	input logic [`PIPE_DATA_W-1:0] rs_data,
	input logic [`PIPE_DATA_W-1:0] rt_data,
	input logic                    wb_valid,
	input logic [`PIPE_DATA_W-1:0] wb_pc,
	input pipe_pkg::opcode_t       wb_opcode
);

	// empty slot, register numbers read as r0
	localparam pipe_pkg::stage_t EMPTY = '{valid: 1'b0, pc: '0, opcode: pipe_pkg::NOP,
		rs: '0, rt: '0, imm: '0, dren: 1'b0};

	int unsigned fail_count = 0;

	// reference slots for decode, execute, memory and writeback
	pipe_pkg::stage_t d, x, m, w;
	pipe_pkg::stage_t fetched;
	logic x_eq, m_eq;
	logic [`PIPE_DATA_W-1:0] exp_pc, pc_q, m_target, target_q, x_offset;
	logic load_use, taken;

	function automatic void flag_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$error("** Error t=%0t %s: got %h expected %h", $time, sig, got, exp);
		fail_count++;
	endfunction

	// record of the word entering decode, issue pc from the reference pc
	always_comb begin
		fetched.valid  = 1'b1;
		fetched.pc     = exp_pc;
		fetched.opcode = pipe_pkg::opcode_t'(instr[31:26]);
		fetched.rs     = instr[25:21];
		fetched.rt     = instr[20:16];
		fetched.imm    = instr[15:0];
		fetched.dren   = (instr[31:26] == pipe_pkg::LW);
	end

	// load in execute whose rt is read by the word in decode
	assign load_use = x.valid && x.dren && ((x.rt == d.rs) || (x.rt == d.rt));
	// beq on equal or bne on unequal operands in memory
	assign taken = m.valid && (((m.opcode == pipe_pkg::BEQ) && m_eq) ||
		((m.opcode == pipe_pkg::BNE) && !m_eq));
	// word offset of the branch, sign extended
	assign x_offset = {{(`PIPE_DATA_W-`PIPE_IMM_W){x.imm[`PIPE_IMM_W-1]}}, x.imm} << 2;

	always_ff @(posedge CLK) begin
		pc_q     <= pc;
		target_q <= m_target;
		if (reset) begin
			exp_pc <= `PIPE_RESET_PC;
			d      <= EMPTY;
			x      <= EMPTY;
			m      <= EMPTY;
			w      <= EMPTY;
		end
		else if (ihit) begin
			w <= m;
			if (taken) begin
				// redirect, the three younger slots are dropped
				exp_pc <= m_target;
				d      <= EMPTY;
				x      <= EMPTY;
				m      <= EMPTY;
			end
			else begin
				m        <= x;
				m_eq     <= x_eq;
				m_target <= x.pc + `PIPE_DATA_W'(4) + x_offset;
				if (load_use) begin
					// decode and pc wait one cycle behind a bubble
					x <= EMPTY;
				end
				else begin
					exp_pc <= exp_pc + `PIPE_DATA_W'(4);
					x      <= d;
					x_eq   <= (rs_data == rt_data);
					d      <= fetched;
				end
			end
		end
	end

	// reset pc and an empty writeback
	a_reset_pc: assert property (@(posedge CLK) reset |=> (pc == `PIPE_RESET_PC))
		else flag_mismatch("pc", $sampled(pc), `PIPE_RESET_PC);
	a_reset_wb: assert property (@(posedge CLK) reset |=> !wb_valid)
		else flag_mismatch("wb_valid", {31'b0, $sampled(wb_valid)}, 32'd0);
	// a miss freezes the pc
	a_miss_hold: assert property (@(posedge CLK) (!reset && !ihit) |=> (pc == pc_q))
		else flag_mismatch("pc", $sampled(pc), $sampled(pc_q));
	// load-use costs one cycle of pc
	a_load_use: assert property (@(posedge CLK)
		(!reset && ihit && load_use && !taken) |=> (pc == pc_q))
		else flag_mismatch("pc", $sampled(pc), $sampled(pc_q));
	a_branch: assert property (@(posedge CLK) (!reset && ihit && taken) |=> (pc == target_q))
		else flag_mismatch("pc", $sampled(pc), $sampled(target_q));
	a_next: assert property (@(posedge CLK)
		(!reset && ihit && !load_use && !taken) |=> (pc == pc_q + `PIPE_DATA_W'(4)))
		else flag_mismatch("pc", $sampled(pc), $sampled(pc_q) + 32'd4);
	// register file read addresses follow the word in decode
	a_rs_addr: assert property (@(posedge CLK) disable iff (reset) (rs_addr == d.rs))
		else flag_mismatch("rs_addr", 32'($sampled(rs_addr)), 32'($sampled(d.rs)));
	a_rt_addr: assert property (@(posedge CLK) disable iff (reset) (rt_addr == d.rt))
		else flag_mismatch("rt_addr", 32'($sampled(rt_addr)), 32'($sampled(d.rt)));
	// flushed words never retire, survivors retire with their issue pc
	a_retire: assert property (@(posedge CLK) disable iff (reset) (wb_valid == w.valid))
		else flag_mismatch("wb_valid", {31'b0, $sampled(wb_valid)}, {31'b0, $sampled(w.valid)});
	a_retire_pc: assert property (@(posedge CLK) disable iff (reset)
		wb_valid |-> (wb_pc == w.pc))
		else flag_mismatch("wb_pc", $sampled(wb_pc), $sampled(w.pc));
	a_retire_op: assert property (@(posedge CLK) disable iff (reset)
		wb_valid |-> (wb_opcode == w.opcode))
		else flag_mismatch("wb_opcode", 32'($sampled(wb_opcode)), 32'($sampled(w.opcode)));

endmodule

//--- dv/pipe_ctrl_tb.sv
// random instruction stream for the pipeline control block, checks sit in pipe_ctrl_chk
// registers are drawn from r0..r3 so load-use pairs come up often
// ihit drops about one cycle in eight
`timescale 1ns/100ps
`include "pipe_config.svh"

module pipe_ctrl_tb;

	localparam int RESET_CYCLES = 2;
	localparam int RUN_CYCLES   = 600;
	localparam int DRAIN_CYCLES = 8;
	// whole run plus a little slack
	localparam int LIMIT_CYCLES = RESET_CYCLES + RUN_CYCLES + DRAIN_CYCLES + 10;

	logic                    CLK = 1'b0;
	logic                    reset, ihit, wb_valid;
	logic [`PIPE_DATA_W-1:0] instr, pc, rs_data, rt_data, wb_pc;
	logic [`PIPE_REG_W-1:0]  rs_addr, rt_addr;
	pipe_pkg::opcode_t       wb_opcode;
	logic [31:0]             lfsr_state = 32'h8b13;
	int                      cycle_count = 0;
	int unsigned             error_count;

	pipe_ctrl_top i_dut (.*);

	bind pipe_ctrl_top pipe_ctrl_chk i_chk (.*);

	always #4 CLK = ~CLK;

	// galois step, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// n random bits, one lfsr step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return r;
	endfunction

	// one random word, its operand data and the hit level
	task automatic drive_cycle();
		logic [2:0]  pick;
		logic [4:0]  imm5;
		logic [31:0] word, data;
		pipe_pkg::opcode_t op;
		pick = 3'(take_bits(3));
		case (pick)
			3'd0:       op = pipe_pkg::BEQ;
			3'd1:       op = pipe_pkg::BNE;
			3'd2, 3'd3: op = pipe_pkg::LW;
			3'd4:       op = pipe_pkg::SW;
			3'd5:       op = pipe_pkg::ADDI;
			default:    op = pipe_pkg::RTYPE;
		endcase
		imm5 = 5'(take_bits(5));
		word[31:26] = op;
		word[25:21] = 5'(take_bits(2));
		word[20:16] = 5'(take_bits(2));
		// short signed branch offset
		word[15:0] = {{11{imm5[4]}}, imm5};
		data = take_bits(16);
		ihit    <= (take_bits(3) != 0);
		instr   <= word;
		rs_data <= data;
		// equal or different operands decide the branch outcome
		rt_data <= take_bits(1) ? data : ~data;
	endtask

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= LIMIT_CYCLES) begin
			$display("timeout after %0d cycles, the stimulus did not finish", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		reset   = 1'b1;
		ihit    = 1'b0;
		instr   = '0;
		rs_data = '0;
		rt_data = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		reset <= 1'b0;
		repeat (RUN_CYCLES) begin
			@(posedge CLK);
			drive_cycle();
		end
		// let the last words retire
		ihit <= 1'b1;
		repeat (DRAIN_CYCLES) @(posedge CLK);
		@(negedge CLK);
		error_count = i_dut.i_chk.fail_count;
		$display("assertion failures: %0d", error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end
		else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- rtl/hazard_if.sv
// hazard signals between the stage registers, hazard unit and pc unit
// stage fields arrive already qualified by their valid bits
`timescale 1ns/100ps
`include "pipe_config.svh"

interface hazard_if;

	// instruction hit level, driven from the top
	logic ihit;

	// stage fields seen by the hazard unit
	pipe_pkg::opcode_t       opcode_ex_mem;
	logic                    zero_ex_mem;
	logic [`PIPE_REG_W-1:0]  rs_if_id;
	logic [`PIPE_REG_W-1:0]  rt_if_id;
	logic [`PIPE_REG_W-1:0]  rt_id_ex;
	logic                    dren_id_ex;

	// branch target formed in ex/mem
	logic [`PIPE_DATA_W-1:0] branch_target;

	// pc control
	pipe_pkg::pc_sel_t       pcsrc;
	logic                    enable_pc;

	// per stage enables and flushes
	logic enable_if_id, enable_id_ex, enable_ex_mem, enable_mem_wb;
	logic flush_if_id, flush_id_ex, flush_ex_mem, flush_mem_wb;

	modport stages (
		output opcode_ex_mem, zero_ex_mem, rs_if_id, rt_if_id, rt_id_ex, dren_id_ex,
		output branch_target,
		input  enable_if_id, enable_id_ex, enable_ex_mem, enable_mem_wb,
		input  flush_if_id, flush_id_ex, flush_ex_mem, flush_mem_wb
	);

	modport hazard (
		input  ihit, opcode_ex_mem, zero_ex_mem, rs_if_id, rt_if_id, rt_id_ex, dren_id_ex,
		output pcsrc, enable_pc,
		output enable_if_id, enable_id_ex, enable_ex_mem, enable_mem_wb,
		output flush_if_id, flush_id_ex, flush_ex_mem, flush_mem_wb
	);

	modport pc (
		input ihit, pcsrc, enable_pc, branch_target
	);

endinterface

//--- rtl/hazard_unit.sv
// load-use and branch hazard detection, purely combinational
// no forwarding exists, so any load-use match costs one stall cycle
// a taken branch wins over a load-use stall in the same cycle
`timescale 1ns/100ps
`include "pipe_config.svh"

module hazard_unit (
	hazard_if.hazard hif
);

	logic load_use_flag;
	logic branch_taken_flag;

	// taken branch resolved in ex/mem
	always_comb begin : branch_detect
		branch_taken_flag = 1'b0;
		// beq taken on equal operands
		if ((hif.opcode_ex_mem == pipe_pkg::BEQ) && hif.zero_ex_mem) begin
			branch_taken_flag = 1'b1;
		end
		// bne taken on unequal operands
		else if ((hif.opcode_ex_mem == pipe_pkg::BNE) && !hif.zero_ex_mem) begin
			branch_taken_flag = 1'b1;
		end
	end

	// load in id/ex whose destination is read by the instruction in if/id
	always_comb begin : load_use_detect
		load_use_flag = 1'b0;
		if (hif.dren_id_ex &&
			((hif.rt_id_ex == hif.rs_if_id) || (hif.rt_id_ex == hif.rt_if_id))) begin
			load_use_flag = 1'b1;
		end
	end

	always_comb begin : pcsrc_enable_flush
		// every stage and the pc follow ihit by default
		hif.pcsrc         = pipe_pkg::SEL_NEXT;
		hif.enable_pc     = hif.ihit;
		hif.enable_if_id  = hif.ihit;
		hif.enable_id_ex  = hif.ihit;
		hif.enable_ex_mem = hif.ihit;
		hif.enable_mem_wb = hif.ihit;
		hif.flush_if_id   = 1'b0;
		hif.flush_id_ex   = 1'b0;
		hif.flush_ex_mem  = 1'b0;
		hif.flush_mem_wb  = 1'b0;

		if (hif.ihit && branch_taken_flag) begin
			// redirect fetch to the branch target
			hif.pcsrc        = pipe_pkg::SEL_BRANCH;
			// drop the three younger instructions
			hif.flush_if_id  = 1'b1;
			hif.flush_id_ex  = 1'b1;
			hif.flush_ex_mem = 1'b1;
		end
		else if (hif.ihit && load_use_flag) begin
			// hold pc and if/id for one cycle
			hif.enable_pc    = 1'b0;
			hif.enable_if_id = 1'b0;
			// bubble into id/ex while the load moves on
			hif.flush_id_ex  = 1'b1;
		end
	end

endmodule

//--- rtl/pc_unit.sv
// program counter with hold, increment and branch target load
// advances only on a cycle with ihit high and enable_pc set
`timescale 1ns/100ps
`include "pipe_config.svh"

module pc_unit (
	input  logic                    CLK,
	input  logic                    reset,
	output logic [`PIPE_DATA_W-1:0] pc,
	hazard_if.pc                    hif
);

	logic [`PIPE_DATA_W-1:0] pc_plus4;
	logic [`PIPE_DATA_W-1:0] pc_next;
	logic                    pc_load;

	// sequential fetch address
	assign pc_plus4 = pc + `PIPE_DATA_W'(4);

	// target chosen by the hazard unit
	always_comb begin
		case (hif.pcsrc)
			pipe_pkg::SEL_BRANCH: pc_next = hif.branch_target;
			default:              pc_next = pc_plus4;
		endcase
	end

	// a miss holds fetch regardless of the hazard decision
	assign pc_load = hif.ihit & hif.enable_pc;

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= `PIPE_RESET_PC;
		end
		else if (pc_load) begin
			pc <= pc_next;
		end
	end

endmodule

//--- rtl/pipe_config.svh
// fixed build values for the pipeline control block
// nothing here is meant to be overridden per instance
// reset pc must be word aligned, the pc unit steps by 4
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// pc value loaded on reset
`define PIPE_RESET_PC 32'h0000_0000

// width of pc, instruction and register data words
`define PIPE_DATA_W 32

// width of a register number, 32 architectural registers
`define PIPE_REG_W 5

// width of the i-type immediate field
`define PIPE_IMM_W 16

`endif

//--- rtl/pipe_ctrl_top.sv
// pipeline control top, plain ports only
// ihit is the sole flow control, low ihit freezes every stage and the pc
// register file sits outside and must answer rs_addr/rt_addr in the same cycle
`timescale 1ns/100ps
`include "pipe_config.svh"

module pipe_ctrl_top (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic                    ihit,
	input  logic [`PIPE_DATA_W-1:0] instr,
	output logic [`PIPE_DATA_W-1:0] pc,
	output logic [`PIPE_REG_W-1:0]  rs_addr,
	output logic [`PIPE_REG_W-1:0]  rt_addr,
	input  logic [`PIPE_DATA_W-1:0] rs_data,
	input  logic [`PIPE_DATA_W-1:0] rt_data,
	output logic                    wb_valid,
	output logic [`PIPE_DATA_W-1:0] wb_pc,
	output pipe_pkg::opcode_t       wb_opcode
);

	// hazard signal bundle shared by the three blocks
	hazard_if hif ();

	// instruction hit enters the bundle here
	assign hif.ihit = ihit;

	// pipeline registers, decode and branch compare
	stage_regs i_stage_regs (
		.CLK       (CLK),
		.reset     (reset),
		.instr     (instr),
		.pc        (pc),
		.rs_addr   (rs_addr),
		.rt_addr   (rt_addr),
		.rs_data   (rs_data),
		.rt_data   (rt_data),
		.wb_valid  (wb_valid),
		.wb_pc     (wb_pc),
		.wb_opcode (wb_opcode),
		.hif       (hif.stages)
	);

	// stall, flush and pc source decisions
	hazard_unit i_hazard_unit (
		.hif (hif.hazard)
	);

	// fetch address
	pc_unit i_pc_unit (
		.CLK   (CLK),
		.reset (reset),
		.pc    (pc),
		.hif   (hif.pc)
	);

endmodule

//--- rtl/pipe_pkg.sv
// shared types for the pipeline control block
// opcode encodings follow the classic mips values, NOP is a private bubble code
`include "pipe_config.svh"

package pipe_pkg;

	// primary opcode field, NOP never comes from memory
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		LW    = 6'h23,
		SW    = 6'h2b,
		NOP   = 6'h3f
	} opcode_t;

	// r-type view of an instruction word
	typedef struct packed {
		logic [5:0]             opcode;
		logic [`PIPE_REG_W-1:0] rs;
		logic [`PIPE_REG_W-1:0] rt;
		logic [`PIPE_REG_W-1:0] rd;
		logic [4:0]             shamt;
		logic [5:0]             funct;
	} r_fields_t;

	// i-type view of the same word
	typedef struct packed {
		logic [5:0]             opcode;
		logic [`PIPE_REG_W-1:0] rs;
		logic [`PIPE_REG_W-1:0] rt;
		logic [`PIPE_IMM_W-1:0] imm;
	} i_fields_t;

	// one 32 bit word, two decodings
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} instr_u;

	// pc source select
	typedef enum logic {
		SEL_NEXT   = 1'b0,
		SEL_BRANCH = 1'b1
	} pc_sel_t;

	// bookkeeping carried by every pipeline register
	typedef struct packed {
		logic                    valid;
		logic [`PIPE_DATA_W-1:0] pc;
		opcode_t                 opcode;
		logic [`PIPE_REG_W-1:0]  rs;
		logic [`PIPE_REG_W-1:0]  rt;
		logic [`PIPE_IMM_W-1:0]  imm;
		// set for a load
		logic                    dren;
	} stage_t;

endpackage

//--- rtl/stage_regs.sv
// if/id, id/ex, ex/mem and mem/wb bookkeeping registers
// register file is outside, read combinationally from the if/id fields
// a flush writes a bubble, an enable low holds the stage
`timescale 1ns/100ps
`include "pipe_config.svh"

module stage_regs (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic [`PIPE_DATA_W-1:0] instr,
	input  logic [`PIPE_DATA_W-1:0] pc,
	output logic [`PIPE_REG_W-1:0]  rs_addr,
	output logic [`PIPE_REG_W-1:0]  rt_addr,
	input  logic [`PIPE_DATA_W-1:0] rs_data,
	input  logic [`PIPE_DATA_W-1:0] rt_data,
	output logic                    wb_valid,
	output logic [`PIPE_DATA_W-1:0] wb_pc,
	output pipe_pkg::opcode_t       wb_opcode,
	hazard_if.stages                hif
);

	// empty slot written on reset and flush
	localparam pipe_pkg::stage_t BUBBLE = '{
		valid:  1'b0,
		pc:     '0,
		opcode: pipe_pkg::NOP,
		rs:     '0,
		rt:     '0,
		imm:    '0,
		dren:   1'b0
	};

	pipe_pkg::instr_u dec;
	pipe_pkg::stage_t fetch_rec;
	pipe_pkg::stage_t if_id, id_ex, ex_mem, mem_wb;

	// operand payload captured in id/ex
	logic [`PIPE_DATA_W-1:0] id_ex_rs_data, id_ex_rt_data;
	// branch compare and target captured in ex/mem
	logic                    ex_mem_zero;
	logic [`PIPE_DATA_W-1:0] ex_mem_target;
	logic [`PIPE_DATA_W-1:0] imm_sext_sh2;

	// decode the fetched word into a stage record
	always_comb begin
		dec              = instr;
		fetch_rec.valid  = 1'b1;
		fetch_rec.pc     = pc;
		fetch_rec.opcode = pipe_pkg::opcode_t'(dec.r_fields.opcode);
		fetch_rec.rs     = dec.r_fields.rs;
		fetch_rec.rt     = dec.r_fields.rt;
		// immediate only exists in the i-type view
		fetch_rec.imm    = dec.i_fields.imm;
		fetch_rec.dren   = (fetch_rec.opcode == pipe_pkg::LW);
	end

	// register file read addresses come from decode
	assign rs_addr = if_id.rs;
	assign rt_addr = if_id.rt;

	// word offset, sign extended
	assign imm_sext_sh2 = {{(`PIPE_DATA_W-`PIPE_IMM_W-2){id_ex.imm[`PIPE_IMM_W-1]}},
		id_ex.imm, 2'b00};

	always_ff @(posedge CLK) begin
		if (reset) begin
			if_id  <= BUBBLE;
			id_ex  <= BUBBLE;
			ex_mem <= BUBBLE;
			mem_wb <= BUBBLE;
		end
		else begin
			// fetch to decode
			if (hif.flush_if_id) if_id <= BUBBLE;
			else if (hif.enable_if_id) if_id <= fetch_rec;
			// decode to execute
			if (hif.flush_id_ex) id_ex <= BUBBLE;
			else if (hif.enable_id_ex) id_ex <= if_id;
			// execute to memory
			if (hif.flush_ex_mem) ex_mem <= BUBBLE;
			else if (hif.enable_ex_mem) ex_mem <= id_ex;
			// memory to writeback
			if (hif.flush_mem_wb) mem_wb <= BUBBLE;
			else if (hif.enable_mem_wb) mem_wb <= ex_mem;
		end
	end

	// payload follows its stage enable, validity lives in the records
	always_ff @(posedge CLK) begin
		if (hif.enable_id_ex) begin
			id_ex_rs_data <= rs_data;
			id_ex_rt_data <= rt_data;
		end
		if (hif.enable_ex_mem) begin
			// branch compare at the end of execute
			ex_mem_zero   <= (id_ex_rs_data == id_ex_rt_data);
			ex_mem_target <= id_ex.pc + `PIPE_DATA_W'(4) + imm_sext_sh2;
		end
	end

	// fields for the hazard unit, qualified by valid
	assign hif.opcode_ex_mem = ex_mem.valid ? ex_mem.opcode : pipe_pkg::NOP;
	assign hif.zero_ex_mem   = ex_mem_zero;
	assign hif.rs_if_id      = if_id.rs;
	assign hif.rt_if_id      = if_id.rt;
	assign hif.rt_id_ex      = id_ex.rt;
	assign hif.dren_id_ex    = id_ex.valid & id_ex.dren;
	assign hif.branch_target = ex_mem_target;

	// retire view
	assign wb_valid  = mem_wb.valid;
	assign wb_pc     = mem_wb.pc;
	assign wb_opcode = mem_wb.opcode;

endmodule
